//--- source/smap_consts.svh
// Build constants for the SelectMAP loopback port
// FIFO depth and pointer width must agree: depth = 2**ptr_w

`ifndef SMAP_CONSTS_SVH
`define SMAP_CONSTS_SVH

// FIFO sizing, also the loop engine's starting credit count
`define SMAP_FIFO_DEPTH 8
`define SMAP_PTR_W      3

// Register map on the 2-bit config address
`define SMAP_ADDR_CTRL  2'd0
`define SMAP_ADDR_MASK  2'd1
`define SMAP_ADDR_STAT  2'd2   // Read only

// Bit positions inside the control register
`define SMAP_CTRL_EN    0
`define SMAP_CTRL_SWAP  1

`endif

//--- source/smap_pkg.sv
// Shared data type for the SelectMAP loopback port
// Byte 0 is the first byte seen on the host bus

`default_nettype none

package smap_pkg;

   //----------------------------------------------------------------------
   // One 32-bit word, read either whole or by bus byte
   //----------------------------------------------------------------------
   typedef union packed {
      logic [31:0]     word;
      logic [0:3][7:0] bytes;   // bytes[0] is the most significant
   } smap_word_t;

endpackage : smap_pkg

`default_nettype wire

//--- source/smap_fifo.sv
// Synchronous first-word-fall-through FIFO, single clock
// Push while full and pop while empty are ignored

`default_nettype none

`include "smap_consts.svh"

module smap_fifo #(
   parameter int DEPTH = `SMAP_FIFO_DEPTH,
   parameter int PTR_W = `SMAP_PTR_W
) (
   input  logic                 user_clk,
   input  logic                 reset,
   input  logic                 push,
   input  logic                 pop,
   input  smap_pkg::smap_word_t wdata,
   output smap_pkg::smap_word_t rdata,
   output logic                 full,
   output logic                 empty,
   output logic [PTR_W:0]       count
);

   import smap_pkg::*;

   smap_word_t       mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic             do_push;
   logic             do_pop;

   assign do_push = push && !full;
   assign do_pop  = pop && !empty;

   assign full  = (count == (PTR_W+1)'(DEPTH));
   assign empty = (count == '0);
   assign rdata = mem[rd_ptr];   // Head word shown without a pop

   // Word storage
   always_ff @(posedge user_clk) begin
      if (do_push) mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge user_clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         // Push and pop together leave the occupancy unchanged
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule : smap_fifo

`default_nettype wire

//--- source/smap_host_port.sv
// SelectMAP slave side: 8-bit host bus to 32-bit FIFO words
// Host must hold off writes while init_b is low, bytes sent then are lost

`default_nettype none

module smap_host_port (
   input  logic                 user_clk,
   input  logic                 reset,
   // Host bus
   input  logic [7:0]           d_in,
   output logic [7:0]           d_out,
   output logic                 d_oe,
   input  logic                 cs_b,
   input  logic                 rdwr_b,
   output logic                 init_b,
   // Receive FIFO write side
   output logic                 rx_push,
   output smap_pkg::smap_word_t rx_wdata,
   input  logic                 rx_full,
   // Transmit FIFO read side
   input  smap_pkg::smap_word_t tx_rdata,
   input  logic                 tx_empty,
   output logic                 tx_pop,
   output logic                 credit_ret
);

   import smap_pkg::*;

   // Write side state
   smap_word_t pack;            // Bytes 0..2 of the word being built
   logic [1:0] wr_idx;
   logic       wr_take;

   // Read side state
   smap_word_t hold;
   logic       hold_valid;
   logic [1:0] rd_idx;

   //----------------------------------------------------------------------
   // Host write path
   //----------------------------------------------------------------------
   assign init_b  = !rx_full;                      // Busy while no free entry
   assign wr_take = !cs_b && !rdwr_b && init_b;
   assign rx_push = wr_take && (wr_idx == 2'd3);   // Fourth byte closes the word

   // Last byte goes straight to the FIFO on the same edge
   always_comb begin
      rx_wdata          = pack;
      rx_wdata.bytes[3] = d_in;
   end

   always_ff @(posedge user_clk) begin
      if (wr_take) pack.bytes[wr_idx] <= d_in;
   end

   always_ff @(posedge user_clk) begin
      if (reset) begin
         wr_idx <= '0;
      end else if (wr_take) begin
         wr_idx <= wr_idx + 1'b1;   // Wraps after byte 3
      end
   end

   //----------------------------------------------------------------------
   // Host read path
   //----------------------------------------------------------------------
   assign d_oe   = !cs_b && rdwr_b && hold_valid;
   assign d_out  = hold.bytes[rd_idx];
   assign tx_pop = !hold_valid && !tx_empty;   // Refill whenever empty

   always_ff @(posedge user_clk) begin
      if (tx_pop) hold <= tx_rdata;
   end

   always_ff @(posedge user_clk) begin
      if (reset) begin
         hold_valid <= 1'b0;
         rd_idx     <= '0;
         credit_ret <= 1'b0;
      end else begin
         credit_ret <= tx_pop;   // One credit per word taken out
         if (tx_pop) begin
            hold_valid <= 1'b1;
            rd_idx     <= '0;
         end else if (d_oe) begin
            rd_idx <= rd_idx + 1'b1;
            if (rd_idx == 2'd3) hold_valid <= 1'b0;   // Word drained
         end
      end
   end

endmodule : smap_host_port

`default_nettype wire

//--- source/loop_engine.sv
// Moves words from the receive FIFO to the transmit FIFO
// Credits track free transmit entries, so the transmit full flag is not needed

`default_nettype none

`include "smap_consts.svh"

module loop_engine (
   input  logic                 user_clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 byte_swap,
   input  logic [31:0]          xor_mask,
   input  smap_pkg::smap_word_t rx_rdata,
   input  logic                 rx_empty,
   output logic                 rx_pop,
   output logic                 tx_push,
   output smap_pkg::smap_word_t tx_wdata,
   input  logic                 credit_ret,
   output logic                 moved
);

   import smap_pkg::*;

   logic [`SMAP_PTR_W:0] credits;
   logic                 move;
   smap_word_t           swapped;

   // At most one word per cycle
   assign move    = enable && !rx_empty && (credits != '0);
   assign rx_pop  = move;
   assign tx_push = move;
   assign moved   = move;

   //----------------------------------------------------------------------
   // Transform, combinational from FIFO head
   //----------------------------------------------------------------------
   always_comb begin
      swapped = rx_rdata;
      if (byte_swap) begin
         for (int i = 0; i < 4; i++) begin
            swapped.bytes[i] = rx_rdata.bytes[3-i];
         end
      end
      tx_wdata.word = swapped.word ^ xor_mask;   // Mask after the swap
   end

   // Credit counter
   always_ff @(posedge user_clk) begin
      if (reset) begin
         credits <= (`SMAP_PTR_W+1)'(`SMAP_FIFO_DEPTH);   // Whole transmit FIFO free
      end else begin
         case ({move, credit_ret})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;             // Spent and returned
         endcase
      end
   end

endmodule : loop_engine

`default_nettype wire

//--- source/loop_cfg_regs.sv
// Control, mask and status registers for the loop engine
// Status counts looped words, wraps at 2**32 and ignores writes

`default_nettype none

`include "smap_consts.svh"

module loop_cfg_regs (
   input  logic        user_clk,
   input  logic        reset,
   input  logic        cfg_we,
   input  logic [1:0]  cfg_addr,
   input  logic [31:0] cfg_wdata,
   output logic [31:0] cfg_rdata,
   input  logic        moved,
   output logic        enable,
   output logic        byte_swap,
   output logic [31:0] xor_mask
);

   logic [31:0] ctrl_word;
   logic [31:0] stat_count;

   // Control register as seen on a read
   always_comb begin
      ctrl_word                  = '0;
      ctrl_word[`SMAP_CTRL_EN]   = enable;
      ctrl_word[`SMAP_CTRL_SWAP] = byte_swap;
   end

   //----------------------------------------------------------------------
   // Writes and the word counter
   //----------------------------------------------------------------------
   always_ff @(posedge user_clk) begin
      if (reset) begin
         enable     <= 1'b0;
         byte_swap  <= 1'b0;
         xor_mask   <= '0;
         stat_count <= '0;
      end else begin
         if (cfg_we && cfg_addr == `SMAP_ADDR_CTRL) begin
            enable    <= cfg_wdata[`SMAP_CTRL_EN];
            byte_swap <= cfg_wdata[`SMAP_CTRL_SWAP];
         end
         if (cfg_we && cfg_addr == `SMAP_ADDR_MASK) xor_mask <= cfg_wdata;
         if (moved) stat_count <= stat_count + 1'b1;
      end
   end

   // Read data, one cycle after the address
   always_ff @(posedge user_clk) begin
      if (reset) begin
         cfg_rdata <= '0;
      end else begin
         case (cfg_addr)
            `SMAP_ADDR_CTRL: cfg_rdata <= ctrl_word;
            `SMAP_ADDR_MASK: cfg_rdata <= xor_mask;
            `SMAP_ADDR_STAT: cfg_rdata <= stat_count;
            default:         cfg_rdata <= '0;   // Unused address
         endcase
      end
   end

endmodule : loop_cfg_regs

`default_nettype wire

//--- source/smap_loopback_top.sv
// SelectMAP loopback subsystem on one clock, user_clk
// Bus appears as separate in, out and output-enable ports, no IO buffers

`default_nettype none

module smap_loopback_top (
   input  logic        user_clk,
   input  logic        reset,
   // Host bus
   input  logic [7:0]  d_in,
   output logic [7:0]  d_out,
   output logic        d_oe,
   input  logic        cs_b,
   input  logic        rdwr_b,
   output logic        init_b,
   // Register bus
   input  logic        cfg_we,
   input  logic [1:0]  cfg_addr,
   input  logic [31:0] cfg_wdata,
   output logic [31:0] cfg_rdata
);

   import smap_pkg::*;

   // Receive path, port to engine
   smap_word_t  rx_wdata;
   smap_word_t  rx_rdata;
   logic        rx_push;
   logic        rx_pop;
   logic        rx_full;
   logic        rx_empty;

   // Transmit path, engine to port
   smap_word_t  tx_wdata;
   smap_word_t  tx_rdata;
   logic        tx_push;
   logic        tx_pop;
   logic        tx_empty;
   logic        credit_ret;

   // Configuration
   logic        enable;
   logic        byte_swap;
   logic [31:0] xor_mask;
   logic        moved;

   smap_host_port u_smap_host_port (
      .user_clk(user_clk), .reset(reset),
      .d_in(d_in), .d_out(d_out), .d_oe(d_oe),
      .cs_b(cs_b), .rdwr_b(rdwr_b), .init_b(init_b),
      .rx_push(rx_push), .rx_wdata(rx_wdata), .rx_full(rx_full),
      .tx_rdata(tx_rdata), .tx_empty(tx_empty), .tx_pop(tx_pop),
      .credit_ret(credit_ret)
   );

   smap_fifo u_rx_fifo (
      .user_clk(user_clk), .reset(reset), .push(rx_push), .pop(rx_pop),
      .wdata(rx_wdata), .rdata(rx_rdata), .full(rx_full), .empty(rx_empty),
      .count()
   );

   // Full flag unused, the engine's credits keep it from overflowing
   smap_fifo u_tx_fifo (
      .user_clk(user_clk), .reset(reset), .push(tx_push), .pop(tx_pop),
      .wdata(tx_wdata), .rdata(tx_rdata), .full(), .empty(tx_empty),
      .count()
   );

   loop_engine u_loop_engine (
      .user_clk(user_clk), .reset(reset),
      .enable(enable), .byte_swap(byte_swap), .xor_mask(xor_mask),
      .rx_rdata(rx_rdata), .rx_empty(rx_empty), .rx_pop(rx_pop),
      .tx_push(tx_push), .tx_wdata(tx_wdata),
      .credit_ret(credit_ret), .moved(moved)
   );

   loop_cfg_regs u_loop_cfg_regs (
      .user_clk(user_clk), .reset(reset),
      .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
      .cfg_rdata(cfg_rdata), .moved(moved),
      .enable(enable), .byte_swap(byte_swap), .xor_mask(xor_mask)
   );

endmodule : smap_loopback_top

`default_nettype wire

//--- verif/tb_smap_loopback.sv
// Testbench for the SelectMAP loopback subsystem, host bus driven 2 units after each edge
// Writes always honor init_b, so the burst test interleaves reads once the port is busy

`default_nettype none

`include "smap_consts.svh"

module tb_smap_loopback;

   localparam int n_entries    = 8;
   localparam int n_burst      = 20;     // Back-pressure words
   localparam int entry_cycles = 60;     // Budget per looped word
   localparam int fixed_cycles = 2000;   // Reset, registers, disabled read attempt
   localparam int read_limit   = 200;    // Cycles allowed for one word to appear

   // Stimulus table {control, mask, input word}
   localparam logic [95:0] stim_table [n_entries] = '{
      {32'h0000_0001, 32'h0000_0000, 32'h0123_4567},
      {32'h0000_0001, 32'h0000_0000, 32'h89ab_cdef},
      {32'h0000_0001, 32'h0000_0000, 32'hdead_beef},
      {32'h0000_0001, 32'h0000_0000, 32'h0000_00ff},
      {32'h0000_0003, 32'h0000_0000, 32'h1122_3344},   // Swap only
      {32'h0000_0003, 32'hffff_0000, 32'ha1b2_c3d4},
      {32'h0000_0001, 32'h5a5a_5a5a, 32'h0f0f_f0f0},   // Mask only
      {32'h0000_0003, 32'h8001_7ffe, 32'hcafe_f00d}
   };

   logic        user_clk;
   logic        reset;
   logic [7:0]  d_in;
   logic [7:0]  d_out;
   logic        d_oe;
   logic        cs_b;
   logic        rdwr_b;
   logic        init_b;
   logic        cfg_we;
   logic [1:0]  cfg_addr;
   logic [31:0] cfg_wdata;
   logic [31:0] cfg_rdata;

   integer      seed;
   int          n_looped;       // Words expected through the engine
   logic        saw_busy;
   logic [31:0] expect_q [$];

   smap_loopback_top u_smap_loopback_top (
      .user_clk(user_clk), .reset(reset),
      .d_in(d_in), .d_out(d_out), .d_oe(d_oe),
      .cs_b(cs_b), .rdwr_b(rdwr_b), .init_b(init_b),
      .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
      .cfg_rdata(cfg_rdata)
   );

   initial user_clk = 1'b0;
   always #20 user_clk = ~user_clk;

   //----------------------------------------------------------------------
   // Checks and reference model
   //----------------------------------------------------------------------
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] got);
      assert (got === expected) else begin
         $display("FAIL time=%0t %s expected=%h got=%h", $time, name, expected, got);
         $display("ERRORS FOUND");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_true(input logic cond, input string what);
      assert (cond) else begin
         $display("Error at time %0t: %s", $time, what);
         $display("ERRORS FOUND");
         $fatal(1, "check failed");
      end
   endtask

   // Byte reversal first, then the mask
   function automatic logic [31:0] loop_result(input logic [31:0] ctrl,
                                               input logic [31:0] mask,
                                               input logic [31:0] data);
      logic [31:0] w;
      w = data;
      if (ctrl[`SMAP_CTRL_SWAP]) begin
         w = {data[7:0], data[15:8], data[23:16], data[31:24]};
      end
      return w ^ mask;
   endfunction

   //----------------------------------------------------------------------
   // Bus tasks, each entered and left at a drive point
   //----------------------------------------------------------------------
   task automatic step();
      @(posedge user_clk);
      #2;
   endtask

   task automatic reg_write(input logic [1:0] addr, input logic [31:0] data);
      cfg_we    = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      step();
      cfg_we    = 1'b0;
   endtask

   task automatic reg_read(input logic [1:0] addr, output logic [31:0] data);
      cfg_addr = addr;
      step();              // cfg_rdata loads at this edge
      data = cfg_rdata;
   endtask

   task automatic write_byte(input logic [7:0] b);
      while (!init_b) begin
         cs_b     = 1'b1;   // Hold off while busy
         saw_busy = 1'b1;
         step();
      end
      cs_b   = 1'b0;
      rdwr_b = 1'b0;
      d_in   = b;
      step();
   endtask

   task automatic write_word(input logic [31:0] w);
      for (int i = 0; i < 4; i++) begin
         write_byte(w[31-8*i -: 8]);   // First byte most significant
      end
      cs_b = 1'b1;
   endtask

   task automatic read_word(input int limit, output logic [31:0] word, output int n_bytes);
      int waited;
      n_bytes = 0;
      waited  = 0;
      word    = '0;
      cs_b    = 1'b0;
      rdwr_b  = 1'b1;
      #1;                  // Let d_oe settle
      while (n_bytes < 4 && waited < limit) begin
         if (d_oe) begin
            word    = {word[23:0], d_out};
            n_bytes = n_bytes + 1;
         end
         waited = waited + 1;
         step();
      end
      cs_b = 1'b1;
   endtask

   // Read one word and compare with the oldest expected one
   task automatic drain_one();
      logic [31:0] rd;
      logic [31:0] expected;
      int          nb;
      read_word(read_limit, rd, nb);
      check_true(nb == 4, "timed out waiting for d_oe on a queued word");
      expected = expect_q.pop_front();
      check_value("d_out word", expected, rd);
   endtask

   //----------------------------------------------------------------------
   // Test sequence
   //----------------------------------------------------------------------
   initial begin
      logic [31:0] rd;
      logic [31:0] ctrl;
      logic [31:0] mask;
      logic [31:0] data;
      int          nb;
      seed      = 32'hdf44;
      n_looped  = 0;
      saw_busy  = 1'b0;
      reset     = 1'b1;
      d_in      = 8'h00;
      cs_b      = 1'b1;
      rdwr_b    = 1'b1;
      cfg_we    = 1'b0;
      cfg_addr  = 2'd0;
      cfg_wdata = 32'h0;
      repeat (10) step();
      reset = 1'b0;
      step();

      // Registers after reset, then write and read back
      reg_read(`SMAP_ADDR_CTRL, rd);
      check_value("cfg_rdata ctrl", 32'h0, rd);
      reg_read(`SMAP_ADDR_MASK, rd);
      check_value("cfg_rdata mask", 32'h0, rd);
      reg_read(`SMAP_ADDR_STAT, rd);
      check_value("cfg_rdata stat", 32'h0, rd);
      reg_write(`SMAP_ADDR_CTRL, 32'h0000_0003);
      reg_read(`SMAP_ADDR_CTRL, rd);
      check_value("cfg_rdata ctrl", 32'h0000_0003, rd);
      reg_write(`SMAP_ADDR_MASK, 32'ha5c3_0f96);
      reg_read(`SMAP_ADDR_MASK, rd);
      check_value("cfg_rdata mask", 32'ha5c3_0f96, rd);
      reg_write(`SMAP_ADDR_STAT, 32'h1234_5678);   // Read only
      reg_read(`SMAP_ADDR_STAT, rd);
      check_value("cfg_rdata stat", 32'h0, rd);

      // Table entries, plain loopback then swap and mask
      for (int i = 0; i < n_entries; i++) begin
         ctrl = stim_table[i][95:64];
         mask = stim_table[i][63:32];
         data = stim_table[i][31:0];
         reg_write(`SMAP_ADDR_CTRL, ctrl);
         reg_write(`SMAP_ADDR_MASK, mask);
         write_word(data);
         n_looped = n_looped + 1;
         read_word(read_limit, rd, nb);
         check_true(nb == 4, "timed out waiting for d_oe on a table word");
         check_value("d_out word", loop_result(ctrl, mask, data), rd);
      end

      // Engine disabled, the word must wait in the receive FIFO
      reg_write(`SMAP_ADDR_CTRL, 32'h0);
      reg_write(`SMAP_ADDR_MASK, 32'h0);
      data = 32'h3c5a_96e1;
      write_word(data);
      read_word(50, rd, nb);
      check_true(nb == 0, "d_oe went high while the loop engine was disabled");
      reg_write(`SMAP_ADDR_CTRL, 32'h0000_0001);
      n_looped = n_looped + 1;
      read_word(read_limit, rd, nb);
      check_true(nb == 4, "timed out waiting for d_oe after enable");
      check_value("d_out word", loop_result(32'h1, 32'h0, data), rd);

      // Back-pressure burst
      for (int w = 0; w < n_burst; w++) begin
         if (!init_b) begin
            saw_busy = 1'b1;
            drain_one();   // Free one slot so the next word can go in
         end
         data = $random(seed);
         expect_q.push_back(loop_result(32'h1, 32'h0, data));
         write_word(data);
         n_looped = n_looped + 1;
      end
      while (expect_q.size() > 0) drain_one();
      check_true(saw_busy, "init_b never went low during the burst");

      reg_read(`SMAP_ADDR_STAT, rd);
      check_value("cfg_rdata stat", n_looped, rd);

      $display("NO ERRORS");
      $finish;
   end

   // Watchdog
   initial begin
      int limit;
      limit = (n_entries + n_burst + 1) * entry_cycles + fixed_cycles;
      repeat (limit) @(posedge user_clk);
      $display("Watchdog expired after %0d cycles, the run hung", limit);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
   end

endmodule : tb_smap_loopback

`default_nettype wire

//--- all.f
+incdir+source
source/smap_pkg.sv
source/smap_fifo.sv
source/smap_host_port.sv
source/loop_engine.sv
source/loop_cfg_regs.sv
source/smap_loopback_top.sv
verif/tb_smap_loopback.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_smap_loopback
FILELIST  = all.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^NO ERRORS$$"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
